// File: sim.f
verilog/vertex_pkg.sv
verilog/job_fsm.sv
verilog/batch_counter.sv
verilog/vertex_line_buffer.sv
verilog/vertex_assembler.sv
verilog/vertex_job_fifo.sv
verilog/vertex_job_control.sv
verif/tb_vertex_job_control.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module tb_vertex_job_control; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_vertex_job_control)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verif/tb_vertex_job_control.sv
`timescale 1ns/1ps

module tb_vertex_job_control;

	logic                clock;
	logic                rstn;
	logic                start;
	vertex_pkg::count_t  num_vertices;
	vertex_pkg::addr_t   in_degree_base;
	vertex_pkg::addr_t   out_degree_base;
	vertex_pkg::addr_t   edges_idx_base;
	logic                resp_valid;
	vertex_pkg::struct_t resp_struct;
	vertex_pkg::line_t   resp_data;
	logic                vertex_request;
	logic                read_valid;
	vertex_pkg::addr_t   read_addr;
	vertex_pkg::bsize_t  read_size;
	vertex_pkg::struct_t read_struct;
	logic                vertex_valid;
	vertex_pkg::count_t  vertex_id;
	vertex_pkg::word_t   vertex_in_degree;
	vertex_pkg::word_t   vertex_out_degree;
	vertex_pkg::word_t   vertex_edges_idx;
	vertex_pkg::count_t  filtered_count;
	logic                job_done;

	// current job as the testbench sees it
	int                cur_n;
	vertex_pkg::addr_t cur_in;
	vertex_pkg::addr_t cur_out;
	vertex_pkg::addr_t cur_edges;
	int                cmd_seen;
	int                pops;
	int                exp_idx;
	bit                hold_pops;
	bit                done_seen;

	// memory model command queue
	vertex_pkg::addr_t   q_addr[$];
	vertex_pkg::struct_t q_struct[$];
	bit                  armed;
	int                  resp_delay;

	logic [15:0] lfsr_state;

	vertex_job_control u_vertex_job_control (
		.clock             (clock),
		.rstn              (rstn),
		.start             (start),
		.num_vertices      (num_vertices),
		.in_degree_base    (in_degree_base),
		.out_degree_base   (out_degree_base),
		.edges_idx_base    (edges_idx_base),
		.resp_valid        (resp_valid),
		.resp_struct       (resp_struct),
		.resp_data         (resp_data),
		.vertex_request    (vertex_request),
		.read_valid        (read_valid),
		.read_addr         (read_addr),
		.read_size         (read_size),
		.read_struct       (read_struct),
		.vertex_valid      (vertex_valid),
		.vertex_id         (vertex_id),
		.vertex_in_degree  (vertex_in_degree),
		.vertex_out_degree (vertex_out_degree),
		.vertex_edges_idx  (vertex_edges_idx),
		.filtered_count    (filtered_count),
		.job_done          (job_done)
	);

	always #50 clock = ~clock;

	//////////////////////////////
	// error reporting
	//////////////////////////////

	task automatic stop_on_error();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic abort_test(input string msg);
		$display("%s", msg);
		stop_on_error();
	endtask

	task automatic compare_addr(input string name, input vertex_pkg::addr_t got,
		input vertex_pkg::addr_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_size(input string name, input vertex_pkg::bsize_t got,
		input vertex_pkg::bsize_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_struct(input string name, input vertex_pkg::struct_t got,
		input vertex_pkg::struct_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_count(input string name, input vertex_pkg::count_t got,
		input vertex_pkg::count_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic compare_word(input string name, input vertex_pkg::word_t got,
		input vertex_pkg::word_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_on_error();
		end
	endtask

	//////////////////////////////
	// random numbers and reference
	//////////////////////////////

	// galois lfsr, one step per bit taken
	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			v = (v << 1) | int'(lfsr_state[0]);
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 16'hb400;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
		end
		return v;
	endfunction

	// out-degree arrays sit at 0x2xxx_xxxx with 64 KiB aligned bases
	function automatic vertex_pkg::word_t ref_word(input vertex_pkg::addr_t a);
		vertex_pkg::word_t v;
		int idx;
		v = (a * 32'h9e37_79b1) ^ 32'h00c0_ffee;
		idx = int'(a[15:2]);
		if (a[31:28] == 4'h2) begin
			if (idx % 5 == 3) begin
				v = '0;
			end else begin
				v = v | 32'h1;
			end
		end
		return v;
	endfunction

	// memory keeps each word big-endian
	function automatic vertex_pkg::line_t mem_line(input vertex_pkg::addr_t a);
		vertex_pkg::line_t l;
		vertex_pkg::word_t w;
		l = '0;
		for (int i = 0; i < vertex_pkg::LINE_WORDS; i++) begin
			w = ref_word(a + vertex_pkg::addr_t'(vertex_pkg::WORD_BYTES * i));
			for (int b = 0; b < 4; b++) begin
				l[32*i + 8*b +: 8] = w[8*(3-b) +: 8];
			end
		end
		return l;
	endfunction

	function automatic void ref_vertex(input int i, output vertex_pkg::word_t e_in,
		output vertex_pkg::word_t e_out, output vertex_pkg::word_t e_edges);
		vertex_pkg::addr_t off;
		off = vertex_pkg::addr_t'(vertex_pkg::WORD_BYTES * i);
		e_in    = ref_word(cur_in + off);
		e_out   = ref_word(cur_out + off);
		e_edges = ref_word(cur_edges + off);
	endfunction

	function automatic bit is_kept(input int i);
		return ref_word(cur_out + vertex_pkg::addr_t'(vertex_pkg::WORD_BYTES * i)) != '0;
	endfunction

	function automatic int next_kept(input int i);
		int j;
		j = i;
		while (j < cur_n && !is_kept(j)) j++;
		return j;
	endfunction

	function automatic int kept_before(input int k);
		int c;
		c = 0;
		for (int i = 0; i < k && i < cur_n; i++) begin
			if (is_kept(i)) c++;
		end
		return c;
	endfunction

	function automatic int filtered_expected(input int n);
		int c;
		c = 0;
		for (int i = 0; i < n; i++) begin
			if (i % 5 == 3) c++;
		end
		return c;
	endfunction

	function automatic int batch_size(input int b);
		int r;
		r = cur_n - vertex_pkg::LINE_WORDS * b;
		return (r < vertex_pkg::LINE_WORDS) ? r : vertex_pkg::LINE_WORDS;
	endfunction

	//////////////////////////////
	// per-cycle model and checks
	//////////////////////////////

	task automatic watch_commands();
		int b;
		int w;
		vertex_pkg::addr_t base;
		if (read_valid) begin
			b = cmd_seen / 3;
			w = cmd_seen % 3;
			if (vertex_pkg::LINE_WORDS * b >= cur_n) abort_test("read command after the last batch");
			base = (w == 0) ? cur_in : ((w == 1) ? cur_out : cur_edges);
			compare_struct("read_struct", read_struct, vertex_pkg::struct_t'(w));
			compare_addr("read_addr", read_addr,
				base + vertex_pkg::addr_t'(vertex_pkg::LINE_BYTES * b));
			compare_size("read_size", read_size,
				vertex_pkg::bsize_t'(vertex_pkg::WORD_BYTES * batch_size(b)));
			// whole batch must fit in the fifo when it begins
			if (w == 0 && kept_before(vertex_pkg::LINE_WORDS * b) - pops >
				vertex_pkg::FIFO_DEPTH - vertex_pkg::LINE_WORDS) begin
				abort_test("batch issued while the job FIFO had no room for it");
			end
			q_addr.push_back(read_addr);
			q_struct.push_back(read_struct);
			cmd_seen++;
		end
	endtask

	task automatic serve_responses();
		int j;
		vertex_pkg::addr_t   ta;
		vertex_pkg::struct_t ts;
		if (!armed && q_addr.size() == 3) begin
			// random response order per batch
			for (int i = 2; i > 0; i--) begin
				j = int'(rand_bits(2)) % (i + 1);
				ta = q_addr[i];
				ts = q_struct[i];
				q_addr[i] = q_addr[j];
				q_struct[i] = q_struct[j];
				q_addr[j] = ta;
				q_struct[j] = ts;
			end
			resp_delay = int'(rand_bits(3));
			armed = 1'b1;
		end
		if (armed) begin
			if (resp_delay > 0) begin
				resp_delay--;
			end else begin
				resp_valid = 1'b1;
				resp_struct = q_struct.pop_front();
				resp_data = mem_line(q_addr.pop_front());
				if (q_addr.size() == 0) begin
					armed = 1'b0;
				end else begin
					resp_delay = int'(rand_bits(3));
				end
			end
		end
	endtask

	task automatic consume_records();
		vertex_pkg::word_t e_in;
		vertex_pkg::word_t e_out;
		vertex_pkg::word_t e_edges;
		if (vertex_valid && !hold_pops) begin
			// pop about three cycles in four
			if (rand_bits(2) != 0) begin
				if (exp_idx >= cur_n) abort_test("record popped beyond the end of the job");
				ref_vertex(exp_idx, e_in, e_out, e_edges);
				compare_count("vertex_id", vertex_id, vertex_pkg::count_t'(exp_idx));
				compare_word("vertex_in_degree", vertex_in_degree, e_in);
				compare_word("vertex_out_degree", vertex_out_degree, e_out);
				compare_word("vertex_edges_idx", vertex_edges_idx, e_edges);
				vertex_request = 1'b1;
				pops++;
				exp_idx = next_kept(exp_idx + 1);
			end
		end
	endtask

	task automatic watch_done();
		if (job_done) begin
			if (done_seen) abort_test("job_done asserted twice for one job");
			compare_count("filtered_count", filtered_count,
				vertex_pkg::count_t'(filtered_expected(cur_n)));
			if (cmd_seen != 3 * ((cur_n + vertex_pkg::LINE_WORDS - 1) / vertex_pkg::LINE_WORDS)) begin
				abort_test("job finished before all read commands were issued");
			end
			done_seen = 1'b1;
		end
	endtask

	always @(posedge clock) begin
		#1;
		vertex_request = 1'b0;
		resp_valid = 1'b0;
		if (rstn) begin
			watch_commands();
			serve_responses();
			consume_records();
			watch_done();
		end
	end

	//////////////////////////////
	// job sequence
	//////////////////////////////

	task automatic check_quiet();
		if (read_valid !== 1'b0 || vertex_valid !== 1'b0 || job_done !== 1'b0) begin
			abort_test("control output active during reset or before the first start");
		end
	endtask

	task automatic run_job(input int n, input vertex_pkg::addr_t in_b,
		input vertex_pkg::addr_t out_b, input vertex_pkg::addr_t edges_b, input bit hold);
		int t;
		@(negedge clock);
		cur_n = n;
		cur_in = in_b;
		cur_out = out_b;
		cur_edges = edges_b;
		cmd_seen = 0;
		pops = 0;
		done_seen = 1'b0;
		hold_pops = hold;
		exp_idx = next_kept(0);
		@(posedge clock);
		#1;
		start = 1'b1;
		num_vertices = vertex_pkg::count_t'(n);
		in_degree_base = in_b;
		out_degree_base = out_b;
		edges_idx_base = edges_b;
		@(posedge clock);
		#1;
		start = 1'b0;
		if (hold) begin
			// consumer stalls long enough to fill the fifo
			repeat (200) @(negedge clock);
			hold_pops = 1'b0;
		end
		t = 0;
		while (!done_seen) begin
			@(negedge clock);
			t++;
			if (t > 20000) abort_test("timeout waiting for job_done");
		end
		t = 0;
		while (exp_idx < cur_n) begin
			@(negedge clock);
			t++;
			if (t > 2000) abort_test("timeout waiting for the consumer to drain the job FIFO");
		end
		@(negedge clock);
		@(negedge clock);
		if (vertex_valid) abort_test("job FIFO still holds records after the job");
	endtask

	initial begin
		clock = 1'b0;
		rstn = 1'b0;
		start = 1'b0;
		num_vertices = '0;
		in_degree_base = '0;
		out_degree_base = '0;
		edges_idx_base = '0;
		resp_valid = 1'b0;
		resp_struct = vertex_pkg::STRUCT_IN_DEGREE;
		resp_data = '0;
		vertex_request = 1'b0;
		lfsr_state = 16'd52;
		cur_n = 0;
		cur_in = '0;
		cur_out = '0;
		cur_edges = '0;
		cmd_seen = 0;
		pops = 0;
		exp_idx = 0;
		hold_pops = 1'b0;
		done_seen = 1'b0;
		armed = 1'b0;
		resp_delay = 0;

		repeat (10) begin
			@(negedge clock);
			check_quiet();
		end
		@(posedge clock);
		#1;
		rstn = 1'b1;
		repeat (5) begin
			@(negedge clock);
			check_quiet();
		end

		// short job, last batch of two
		run_job(10, 32'h1000_0000, 32'h2000_0000, 32'h3000_0000, 1'b0);
		// consumer held off, fifo fills
		run_job(40, 32'h1008_0040, 32'h2004_0000, 32'h3001_0400, 1'b1);
		run_job(23, 32'h1100_0200, 32'h2010_0000, 32'h3300_0000, 1'b0);

		$display("Simulation passed");
		$finish;
	end

endmodule

// File: verilog/vertex_job_control.sv
`timescale 1ns/1ps

module vertex_job_control (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  start,
	input  vertex_pkg::count_t    num_vertices,
	input  vertex_pkg::addr_t     in_degree_base,
	input  vertex_pkg::addr_t     out_degree_base,
	input  vertex_pkg::addr_t     edges_idx_base,
	input  logic                  resp_valid,
	input  vertex_pkg::struct_t   resp_struct,
	input  vertex_pkg::line_t     resp_data,
	input  logic                  vertex_request,
	output logic                  read_valid,
	output vertex_pkg::addr_t     read_addr,
	output vertex_pkg::bsize_t    read_size,
	output vertex_pkg::struct_t   read_struct,
	output logic                  vertex_valid,
	output vertex_pkg::count_t    vertex_id,
	output vertex_pkg::word_t     vertex_in_degree,
	output vertex_pkg::word_t     vertex_out_degree,
	output vertex_pkg::word_t     vertex_edges_idx,
	output vertex_pkg::count_t    filtered_count,
	output logic                  job_done
);

	vertex_pkg::count_t      batch_words;
	logic                    batch_idle;
	logic                    unpack;
	vertex_pkg::fifo_count_t free_slots;

	// unpacked words on their way to the assembler
	logic              word_valid;
	vertex_pkg::word_t in_word;
	vertex_pkg::word_t out_word;
	vertex_pkg::word_t edges_word;

	// assembled record on its way to the fifo
	logic               push;
	vertex_pkg::count_t rec_id;
	vertex_pkg::word_t  rec_in_degree;
	vertex_pkg::word_t  rec_out_degree;
	vertex_pkg::word_t  rec_edges_idx;

	job_fsm u_job_fsm (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.num_vertices    (num_vertices),
		.in_degree_base  (in_degree_base),
		.out_degree_base (out_degree_base),
		.edges_idx_base  (edges_idx_base),
		.batch_idle      (batch_idle),
		.free_slots      (free_slots),
		.read_valid      (read_valid),
		.read_addr       (read_addr),
		.read_size       (read_size),
		.read_struct     (read_struct),
		.batch_words     (batch_words),
		.job_done        (job_done)
	);

	batch_counter u_batch_counter (
		.clock       (clock),
		.rstn        (rstn),
		.read_valid  (read_valid),
		.read_struct (read_struct),
		.batch_words (batch_words),
		.resp_valid  (resp_valid),
		.batch_idle  (batch_idle),
		.unpack      (unpack)
	);

	vertex_line_buffer u_vertex_line_buffer (
		.clock       (clock),
		.rstn        (rstn),
		.resp_valid  (resp_valid),
		.resp_struct (resp_struct),
		.resp_data   (resp_data),
		.unpack      (unpack),
		.word_valid  (word_valid),
		.in_word     (in_word),
		.out_word    (out_word),
		.edges_word  (edges_word)
	);

	vertex_assembler u_vertex_assembler (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start),
		.word_valid     (word_valid),
		.in_word        (in_word),
		.out_word       (out_word),
		.edges_word     (edges_word),
		.push           (push),
		.rec_id         (rec_id),
		.rec_in_degree  (rec_in_degree),
		.rec_out_degree (rec_out_degree),
		.rec_edges_idx  (rec_edges_idx),
		.filtered_count (filtered_count)
	);

	vertex_job_fifo u_vertex_job_fifo (
		.clock             (clock),
		.rstn              (rstn),
		.push              (push),
		.rec_id            (rec_id),
		.rec_in_degree     (rec_in_degree),
		.rec_out_degree    (rec_out_degree),
		.rec_edges_idx     (rec_edges_idx),
		.vertex_request    (vertex_request),
		.vertex_valid      (vertex_valid),
		.vertex_id         (vertex_id),
		.vertex_in_degree  (vertex_in_degree),
		.vertex_out_degree (vertex_out_degree),
		.vertex_edges_idx  (vertex_edges_idx),
		.free_slots        (free_slots)
	);

endmodule

// File: verilog/vertex_job_fifo.sv
`timescale 1ns/1ps

module vertex_job_fifo (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    push,
	input  vertex_pkg::count_t      rec_id,
	input  vertex_pkg::word_t       rec_in_degree,
	input  vertex_pkg::word_t       rec_out_degree,
	input  vertex_pkg::word_t       rec_edges_idx,
	input  logic                    vertex_request,
	output logic                    vertex_valid,
	output vertex_pkg::count_t      vertex_id,
	output vertex_pkg::word_t       vertex_in_degree,
	output vertex_pkg::word_t       vertex_out_degree,
	output vertex_pkg::word_t       vertex_edges_idx,
	output vertex_pkg::fifo_count_t free_slots
);

	// four fields share one slot index
	vertex_pkg::count_t id_mem    [vertex_pkg::FIFO_DEPTH];
	vertex_pkg::word_t  in_mem    [vertex_pkg::FIFO_DEPTH];
	vertex_pkg::word_t  out_mem   [vertex_pkg::FIFO_DEPTH];
	vertex_pkg::word_t  edges_mem [vertex_pkg::FIFO_DEPTH];

	logic [$clog2(vertex_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(vertex_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	vertex_pkg::fifo_count_t                   count;

	always_ff @(posedge clock) begin
		if (push) begin
			id_mem[wr_ptr]    <= rec_id;
			in_mem[wr_ptr]    <= rec_in_degree;
			out_mem[wr_ptr]   <= rec_out_degree;
			edges_mem[wr_ptr] <= rec_edges_idx;
		end
	end

	//////////////////////////////
	// pointers and occupancy
	//////////////////////////////

	// depth is a power of two, pointers wrap by themselves
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (vertex_request) rd_ptr <= rd_ptr + 1'b1;
			case ({push, vertex_request})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign vertex_valid      = (count != '0);
	assign vertex_id         = id_mem[rd_ptr];
	assign vertex_in_degree  = in_mem[rd_ptr];
	assign vertex_out_degree = out_mem[rd_ptr];
	assign vertex_edges_idx  = edges_mem[rd_ptr];

	assign free_slots = vertex_pkg::fifo_count_t'(vertex_pkg::FIFO_DEPTH) - count;

	// the controller only starts a batch when a whole line fits
	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		push |-> (count != vertex_pkg::fifo_count_t'(vertex_pkg::FIFO_DEPTH)));

	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn)
		vertex_request |-> (count != '0));

endmodule

// File: verilog/vertex_assembler.sv
`timescale 1ns/1ps

module vertex_assembler (
	input  logic               clock,
	input  logic               rstn,
	input  logic               start,
	input  logic               word_valid,
	input  vertex_pkg::word_t  in_word,
	input  vertex_pkg::word_t  out_word,
	input  vertex_pkg::word_t  edges_word,
	output logic               push,
	output vertex_pkg::count_t rec_id,
	output vertex_pkg::word_t  rec_in_degree,
	output vertex_pkg::word_t  rec_out_degree,
	output vertex_pkg::word_t  rec_edges_idx,
	output vertex_pkg::count_t filtered_count
);

	vertex_pkg::count_t next_id;
	vertex_pkg::word_t  in_swap;
	vertex_pkg::word_t  out_swap;
	vertex_pkg::word_t  edges_swap;

	// memory order is big-endian
	function automatic vertex_pkg::word_t swap_bytes(input vertex_pkg::word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign in_swap    = swap_bytes(in_word);
	assign out_swap   = swap_bytes(out_word);
	assign edges_swap = swap_bytes(edges_word);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push           <= 1'b0;
			next_id        <= '0;
			filtered_count <= '0;
		end else begin
			push <= word_valid && (out_swap != '0);
			// ids and the drop count restart per job
			if (start) begin
				next_id        <= '0;
				filtered_count <= '0;
			end else if (word_valid) begin
				next_id <= next_id + 1'b1;
				if (out_swap == '0) filtered_count <= filtered_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (word_valid) begin
			rec_id         <= next_id;
			rec_in_degree  <= in_swap;
			rec_out_degree <= out_swap;
			rec_edges_idx  <= edges_swap;
		end
	end

endmodule

// File: verilog/vertex_line_buffer.sv
`timescale 1ns/1ps

module vertex_line_buffer (
	input  logic                clock,
	input  logic                rstn,
	input  logic                resp_valid,
	input  vertex_pkg::struct_t resp_struct,
	input  vertex_pkg::line_t   resp_data,
	input  logic                unpack,
	output logic                word_valid,
	output vertex_pkg::word_t   in_word,
	output vertex_pkg::word_t   out_word,
	output vertex_pkg::word_t   edges_word
);

	// one line per array, indexed by struct_t
	vertex_pkg::line_t lines [3];

	always_ff @(posedge clock) begin
		for (int i = 0; i < 3; i++) begin
			if (resp_valid && resp_struct == vertex_pkg::struct_t'(i)) begin
				lines[i] <= resp_data;
			end else if (unpack) begin
				lines[i] <= lines[i] >> $bits(vertex_pkg::word_t);
			end
		end
	end

	//////////////////////////////
	// word outputs
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			word_valid <= 1'b0;
		end else begin
			word_valid <= unpack;
		end
	end

	// lowest word of each line
	always_ff @(posedge clock) begin
		if (unpack) begin
			in_word    <= lines[vertex_pkg::STRUCT_IN_DEGREE][$bits(vertex_pkg::word_t)-1:0];
			out_word   <= lines[vertex_pkg::STRUCT_OUT_DEGREE][$bits(vertex_pkg::word_t)-1:0];
			edges_word <= lines[vertex_pkg::STRUCT_EDGES_IDX][$bits(vertex_pkg::word_t)-1:0];
		end
	end

endmodule

// File: verilog/batch_counter.sv
`timescale 1ns/1ps

module batch_counter (
	input  logic                clock,
	input  logic                rstn,
	input  logic                read_valid,
	input  vertex_pkg::struct_t read_struct,
	input  vertex_pkg::count_t  batch_words,
	input  logic                resp_valid,
	output logic                batch_idle,
	output logic                unpack
);

	vertex_pkg::pending_t pending;
	vertex_pkg::count_t   words_left;
	// recent unpack strobes still moving through buffer and assembler
	logic [1:0]           unpack_hist;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending <= '0;
		end else begin
			case ({read_valid, resp_valid})
				2'b10: pending <= pending + 1'b1;
				2'b01: pending <= pending - 1'b1;
				default: pending <= pending;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			words_left  <= '0;
			unpack_hist <= '0;
		end else begin
			unpack_hist <= {unpack_hist[0], unpack};
			if (read_valid && read_struct == vertex_pkg::STRUCT_IN_DEGREE) begin
				words_left <= batch_words;
			end else if (unpack) begin
				words_left <= words_left - 1'b1;
			end
		end
	end

	// all lines are in, one word per cycle
	assign unpack = (pending == '0) && (words_left != '0);

	// idle only after the last word has reached the fifo
	assign batch_idle = (pending == '0) && (words_left == '0) && (unpack_hist == '0);

	a_no_wrap: assert property (@(posedge clock) disable iff (!rstn)
		(pending == '0) |=> (pending != 2'd3));

	a_resp_expected: assert property (@(posedge clock) disable iff (!rstn)
		resp_valid |-> (pending != '0));

endmodule

// File: verilog/job_fsm.sv
`timescale 1ns/1ps

module job_fsm (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    start,
	input  vertex_pkg::count_t      num_vertices,
	input  vertex_pkg::addr_t       in_degree_base,
	input  vertex_pkg::addr_t       out_degree_base,
	input  vertex_pkg::addr_t       edges_idx_base,
	input  logic                    batch_idle,
	input  vertex_pkg::fifo_count_t free_slots,
	output logic                    read_valid,
	output vertex_pkg::addr_t       read_addr,
	output vertex_pkg::bsize_t      read_size,
	output vertex_pkg::struct_t     read_struct,
	output vertex_pkg::count_t      batch_words,
	output logic                    job_done
);

	vertex_pkg::fsm_state_t state;
	vertex_pkg::fsm_state_t next_state;

	vertex_pkg::addr_t  in_base;
	vertex_pkg::addr_t  out_base;
	vertex_pkg::addr_t  edges_base;
	vertex_pkg::addr_t  offset;
	vertex_pkg::count_t remaining;
	vertex_pkg::count_t calc_words;

	logic batch_ready;

	// previous batch drained and room for a whole line in the fifo
	assign batch_ready = batch_idle && (free_slots >= vertex_pkg::LINE_WORDS);

	assign calc_words = (remaining < vertex_pkg::LINE_WORDS) ? remaining :
		vertex_pkg::count_t'(vertex_pkg::LINE_WORDS);

	//////////////////////////////
	// state machine
	//////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			vertex_pkg::ST_IDLE: begin
				if (start) next_state = vertex_pkg::ST_LOAD;
			end
			vertex_pkg::ST_LOAD: next_state = vertex_pkg::ST_WAIT;
			vertex_pkg::ST_WAIT: begin
				if (batch_idle && remaining == '0) begin
					next_state = vertex_pkg::ST_IDLE;
				end else if (batch_ready && remaining != '0) begin
					next_state = vertex_pkg::ST_CALC;
				end
			end
			vertex_pkg::ST_CALC: next_state = vertex_pkg::ST_SEND_IN;
			vertex_pkg::ST_SEND_IN: next_state = vertex_pkg::ST_SEND_OUT;
			vertex_pkg::ST_SEND_OUT: next_state = vertex_pkg::ST_SEND_EDGES;
			vertex_pkg::ST_SEND_EDGES: next_state = vertex_pkg::ST_WAIT;
			default: next_state = vertex_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= vertex_pkg::ST_IDLE;
			remaining   <= '0;
			offset      <= '0;
			batch_words <= '0;
		end else begin
			state <= next_state;
			if (state == vertex_pkg::ST_IDLE && start) begin
				remaining <= num_vertices;
			end
			if (state == vertex_pkg::ST_LOAD) begin
				offset <= '0;
			end
			if (state == vertex_pkg::ST_CALC) begin
				batch_words <= calc_words;
				remaining   <= remaining - calc_words;
			end
			// next batch starts one line further on
			if (state == vertex_pkg::ST_SEND_EDGES) begin
				offset <= offset + vertex_pkg::addr_t'(vertex_pkg::LINE_BYTES);
			end
		end
	end

	// bases held for the whole job
	always_ff @(posedge clock) begin
		if (state == vertex_pkg::ST_IDLE && start) begin
			in_base    <= in_degree_base;
			out_base   <= out_degree_base;
			edges_base <= edges_idx_base;
		end
	end

	//////////////////////////////
	// command outputs
	//////////////////////////////

	always_comb begin
		read_valid  = 1'b0;
		read_struct = vertex_pkg::STRUCT_IN_DEGREE;
		read_addr   = in_base + offset;
		case (state)
			vertex_pkg::ST_SEND_IN: read_valid = 1'b1;
			vertex_pkg::ST_SEND_OUT: begin
				read_valid  = 1'b1;
				read_struct = vertex_pkg::STRUCT_OUT_DEGREE;
				read_addr   = out_base + offset;
			end
			vertex_pkg::ST_SEND_EDGES: begin
				read_valid  = 1'b1;
				read_struct = vertex_pkg::STRUCT_EDGES_IDX;
				read_addr   = edges_base + offset;
			end
			default: read_valid = 1'b0;
		endcase
	end

	// exact byte count, no rounding
	assign read_size = vertex_pkg::bsize_t'(batch_words * vertex_pkg::WORD_BYTES);

	assign job_done = (state == vertex_pkg::ST_WAIT) && batch_idle && (remaining == '0);

	// a new job may only be started once the previous one is done
	a_start_in_idle: assert property (@(posedge clock) disable iff (!rstn)
		start |-> state == vertex_pkg::ST_IDLE);

endmodule

// File: verilog/vertex_pkg.sv
package vertex_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// one vertex field in memory or in a record
	typedef logic [31:0] word_t;
	// byte address
	typedef logic [31:0] addr_t;
	// vertex count or vertex id
	typedef logic [31:0] count_t;
	// one returned cache line, word i at bits 32*i upward
	typedef logic [127:0] line_t;
	// read request size in bytes
	typedef logic [7:0] bsize_t;
	// job fifo occupancy or free count
	typedef logic [4:0] fifo_count_t;
	// outstanding responses, at most 3 per batch
	typedef logic [1:0] pending_t;

	//////////////////////////////
	// batch constants
	//////////////////////////////

	localparam int WORD_BYTES = 4;
	localparam int LINE_WORDS = 4;
	localparam int LINE_BYTES = 16;
	localparam int FIFO_DEPTH = 16;

	// array a command or response belongs to
	typedef enum logic [1:0] {
		STRUCT_IN_DEGREE  = 2'd0,
		STRUCT_OUT_DEGREE = 2'd1,
		STRUCT_EDGES_IDX  = 2'd2
	} struct_t;

	// job controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_WAIT,
		ST_CALC,
		ST_SEND_IN,
		ST_SEND_OUT,
		ST_SEND_EDGES
	} fsm_state_t;

endpackage
